// File: Bender.yml
package:
  name: backend

sources:
  - files:
      - hdl/backend_cfg_pkg.sv
      - hdl/backend_op_pkg.sv
      - hdl/alu_unit.sv
      - hdl/mul_unit.sv
      - hdl/issue_stage.sv
      - hdl/reorder_buffer.sv
      - hdl/backend_top.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/tb_backend.sv

// File: all.f
+incdir+tb
hdl/backend_cfg_pkg.sv
hdl/backend_op_pkg.sv
hdl/alu_unit.sv
hdl/mul_unit.sv
hdl/issue_stage.sv
hdl/reorder_buffer.sv
hdl/backend_top.sv
tb/tb_backend.sv

// File: hdl/alu_unit.sv
// ================================================
// Single-cycle integer ALU
// Result, tag and done pulse are registered
// ================================================
`timescale 1ns/1ps
`default_nettype none

module alu_unit
    import backend_cfg_pkg::*;
    import backend_op_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       start_i,
    input  alu_op_t    op_i,
    input  rob_tag_t   tag_i,
    input  data_word_t opnd_a_i,
    input  data_word_t opnd_b_i,
    output logic       done_o,
    output rob_tag_t   tag_o,
    output data_word_t result_o
);

    logic [$clog2(XLEN)-1:0] shamt;
    data_word_t              alu_res;

    // Shifts use only the low bits of b
    assign shamt = opnd_b_i[$clog2(XLEN)-1:0];

    always_comb begin
        case (op_i)
            OP_ADD:  alu_res = opnd_a_i + opnd_b_i;
            OP_SUB:  alu_res = opnd_a_i - opnd_b_i;
            OP_AND:  alu_res = opnd_a_i & opnd_b_i;
            OP_OR:   alu_res = opnd_a_i | opnd_b_i;
            OP_XOR:  alu_res = opnd_a_i ^ opnd_b_i;
            OP_SLL:  alu_res = opnd_a_i << shamt;
            OP_SRL:  alu_res = opnd_a_i >> shamt;
            OP_SLT:  alu_res = data_word_t'($signed(opnd_a_i) < $signed(opnd_b_i));
            // Multiplies never reach this unit
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (!rst_n_i)
            done_o <= 1'b0;
        else
            done_o <= start_i;
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            tag_o    <= tag_i;
            result_o <= alu_res;
        end
    end

endmodule : alu_unit

`default_nettype wire

// File: hdl/backend_cfg_pkg.sv
// ================================================
// Back end configuration constants
// Widths of data, register indices and tags, plus
// the iteration constants of the multiplier
// ================================================
`default_nettype none

package backend_cfg_pkg;

    // ================================================
    // Widths and depths
    // ================================================

    // Integer datapath width
    localparam int XLEN = 32;
    // Architectural register index width
    localparam int REG_ADDR_W = 5;
    // Reorder buffer entries, kept a power of two so tags wrap for free
    localparam int ROB_DEPTH = 8;
    localparam int TAG_W = $clog2(ROB_DEPTH);

    // ================================================
    // Multiplier iteration
    // ================================================

    // Multiplier bits consumed in each iteration
    localparam int MUL_BITS_PER_CYCLE = 4;
    localparam int MUL_CYCLES = XLEN / MUL_BITS_PER_CYCLE;
    // Width of the iteration counter
    localparam int MUL_CNT_W = $clog2(MUL_CYCLES);

    // Vector types used across the back end
    typedef logic [XLEN-1:0] data_word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;
    typedef logic [TAG_W-1:0] rob_tag_t;

endpackage : backend_cfg_pkg

`default_nettype wire

// File: hdl/backend_op_pkg.sv
// ================================================
// Back end operation encoding
// Operation codes, execution unit select and the
// multiplier FSM states
// ================================================
`default_nettype none

package backend_op_pkg;

    // Operations understood by the back end
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_AND = 4'd2,
        OP_OR  = 4'd3,
        OP_XOR = 4'd4,
        OP_SLL = 4'd5,
        OP_SRL = 4'd6,
        OP_SLT = 4'd7,
        OP_MUL = 4'd8
    } alu_op_t;

    // Execution unit that runs an instruction
    typedef enum logic {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } unit_sel_t;

    // Iterative multiplier states
    typedef enum logic {
        MUL_IDLE = 1'b0,
        MUL_BUSY = 1'b1
    } mul_state_t;

    // Only the multiply goes to the slow unit, everything else is single cycle
    function automatic unit_sel_t unit_of(input alu_op_t op);
        return (op == OP_MUL) ? UNIT_MUL : UNIT_ALU;
    endfunction

endpackage : backend_op_pkg

`default_nettype wire

// File: hdl/backend_top.sv
// ================================================
// Integer core back end
// Issue with operand bypass, ALU and multiplier
// execution, in-order retirement via reorder buffer
// ================================================
`timescale 1ns/1ps
`default_nettype none

module backend_top
    import backend_cfg_pkg::*;
    import backend_op_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Issue port
    input  logic       issue_valid_i,
    input  logic       issue_imm_i,
    input  alu_op_t    issue_op_i,
    input  reg_addr_t  issue_dest_i,
    input  reg_addr_t  issue_src_a_i,
    input  reg_addr_t  issue_src_b_i,
    input  data_word_t issue_opnd_a_i,
    input  data_word_t issue_opnd_b_i,
    output logic       stall_o,

    // Register writeback
    output logic       wb_valid_o,
    output reg_addr_t  wb_dest_o,
    output data_word_t wb_result_o
);

    // Reorder buffer allocation and forwarding lookup
    logic       rob_full, rob_alloc;
    reg_addr_t  rob_alloc_dest;
    reg_addr_t  fwd_src_a, fwd_src_b;
    logic       fwd_hit_a, fwd_hit_b, fwd_pending_a, fwd_pending_b;
    data_word_t fwd_data_a, fwd_data_b;

    // Dispatch from the issue register
    logic       alu_start, mul_start, mul_busy;
    alu_op_t    ex_op;
    rob_tag_t   ex_tag;
    data_word_t ex_opnd_a, ex_opnd_b;

    // Completion from the execution units
    logic       alu_done, mul_done;
    rob_tag_t   alu_tag, mul_tag;
    data_word_t alu_result, mul_result;

    issue_stage u_issue (
        .clk_i            ( clk_i          ),
        .rst_n_i          ( rst_n_i        ),
        .issue_valid_i    ( issue_valid_i  ),
        .issue_imm_i      ( issue_imm_i    ),
        .issue_op_i       ( issue_op_i     ),
        .issue_dest_i     ( issue_dest_i   ),
        .issue_src_a_i    ( issue_src_a_i  ),
        .issue_src_b_i    ( issue_src_b_i  ),
        .issue_opnd_a_i   ( issue_opnd_a_i ),
        .issue_opnd_b_i   ( issue_opnd_b_i ),
        .stall_o          ( stall_o        ),
        .rob_full_i       ( rob_full       ),
        .rob_alloc_o      ( rob_alloc      ),
        .rob_alloc_dest_o ( rob_alloc_dest ),
        .fwd_src_a_o      ( fwd_src_a      ),
        .fwd_src_b_o      ( fwd_src_b      ),
        .fwd_hit_a_i      ( fwd_hit_a      ),
        .fwd_hit_b_i      ( fwd_hit_b      ),
        .fwd_pending_a_i  ( fwd_pending_a  ),
        .fwd_pending_b_i  ( fwd_pending_b  ),
        .fwd_data_a_i     ( fwd_data_a     ),
        .fwd_data_b_i     ( fwd_data_b     ),
        .mul_busy_i       ( mul_busy       ),
        .alu_start_o      ( alu_start      ),
        .mul_start_o      ( mul_start      ),
        .ex_op_o          ( ex_op          ),
        .ex_tag_o         ( ex_tag         ),
        .ex_opnd_a_o      ( ex_opnd_a      ),
        .ex_opnd_b_o      ( ex_opnd_b      )
    );

    alu_unit u_alu (
        .clk_i    ( clk_i      ),
        .rst_n_i  ( rst_n_i    ),
        .start_i  ( alu_start  ),
        .op_i     ( ex_op      ),
        .tag_i    ( ex_tag     ),
        .opnd_a_i ( ex_opnd_a  ),
        .opnd_b_i ( ex_opnd_b  ),
        .done_o   ( alu_done   ),
        .tag_o    ( alu_tag    ),
        .result_o ( alu_result )
    );

    mul_unit u_mul (
        .clk_i    ( clk_i      ),
        .rst_n_i  ( rst_n_i    ),
        .start_i  ( mul_start  ),
        .tag_i    ( ex_tag     ),
        .opnd_a_i ( ex_opnd_a  ),
        .opnd_b_i ( ex_opnd_b  ),
        .busy_o   ( mul_busy   ),
        .done_o   ( mul_done   ),
        .tag_o    ( mul_tag    ),
        .result_o ( mul_result )
    );

    reorder_buffer u_rob (
        .clk_i           ( clk_i          ),
        .rst_n_i         ( rst_n_i        ),
        .alloc_i         ( rob_alloc      ),
        .alloc_dest_i    ( rob_alloc_dest ),
        .full_o          ( rob_full       ),
        .alu_done_i      ( alu_done       ),
        .mul_done_i      ( mul_done       ),
        .alu_tag_i       ( alu_tag        ),
        .mul_tag_i       ( mul_tag        ),
        .alu_result_i    ( alu_result     ),
        .mul_result_i    ( mul_result     ),
        .fwd_src_a_i     ( fwd_src_a      ),
        .fwd_src_b_i     ( fwd_src_b      ),
        .fwd_hit_a_o     ( fwd_hit_a      ),
        .fwd_hit_b_o     ( fwd_hit_b      ),
        .fwd_pending_a_o ( fwd_pending_a  ),
        .fwd_pending_b_o ( fwd_pending_b  ),
        .fwd_data_a_o    ( fwd_data_a     ),
        .fwd_data_b_o    ( fwd_data_b     ),
        .wb_valid_o      ( wb_valid_o     ),
        .wb_dest_o       ( wb_dest_o      ),
        .wb_result_o     ( wb_result_o    )
    );

endmodule : backend_top

`default_nettype wire

// File: hdl/issue_stage.sv
// ================================================
// Issue stage
// Operand bypass, stall decision, tag allocation
// and the one-cycle issue register
// ================================================
`timescale 1ns/1ps
`default_nettype none

module issue_stage
    import backend_cfg_pkg::*;
    import backend_op_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    input  logic       issue_valid_i,
    input  logic       issue_imm_i,
    input  alu_op_t    issue_op_i,
    input  reg_addr_t  issue_dest_i,
    input  reg_addr_t  issue_src_a_i,
    input  reg_addr_t  issue_src_b_i,
    input  data_word_t issue_opnd_a_i,
    input  data_word_t issue_opnd_b_i,
    output logic       stall_o,

    // Reorder buffer allocation and lookup
    input  logic       rob_full_i,
    output logic       rob_alloc_o,
    output reg_addr_t  rob_alloc_dest_o,
    output reg_addr_t  fwd_src_a_o,
    output reg_addr_t  fwd_src_b_o,
    input  logic       fwd_hit_a_i,
    input  logic       fwd_hit_b_i,
    input  logic       fwd_pending_a_i,
    input  logic       fwd_pending_b_i,
    input  data_word_t fwd_data_a_i,
    input  data_word_t fwd_data_b_i,

    // Dispatch to the execution units
    input  logic       mul_busy_i,
    output logic       alu_start_o,
    output logic       mul_start_o,
    output alu_op_t    ex_op_o,
    output rob_tag_t   ex_tag_o,
    output data_word_t ex_opnd_a_o,
    output data_word_t ex_opnd_b_o
);

    logic       use_fwd_a, use_fwd_b;
    logic       pend_a, pend_b;
    data_word_t opnd_a, opnd_b;
    logic       mul_wait, accept;
    logic       ex_valid_q;
    unit_sel_t  ex_unit_q;
    rob_tag_t   tag_q;

    // ================================================
    // Operand bypass
    // ================================================

    // Register 0 is hardwired and an immediate b has no producer, so neither looks
    // at the reorder buffer
    assign use_fwd_a = issue_src_a_i != '0;
    assign use_fwd_b = !issue_imm_i && issue_src_b_i != '0;

    assign opnd_a = (use_fwd_a && fwd_hit_a_i) ? fwd_data_a_i : issue_opnd_a_i;
    assign opnd_b = (use_fwd_b && fwd_hit_b_i) ? fwd_data_b_i : issue_opnd_b_i;

    assign pend_a = use_fwd_a && fwd_pending_a_i;
    assign pend_b = use_fwd_b && fwd_pending_b_i;

    assign fwd_src_a_o = issue_src_a_i;
    assign fwd_src_b_o = issue_src_b_i;

    // ================================================
    // Stall and allocation
    // ================================================

    // A multiply parked in the issue register blocks the register itself
    assign mul_wait = ex_valid_q && ex_unit_q == UNIT_MUL && mul_busy_i;

    assign stall_o = issue_valid_i && (pend_a || pend_b || rob_full_i || mul_wait);
    assign accept  = issue_valid_i && !stall_o;

    // Every accepted instruction gets an entry, even with destination 0
    assign rob_alloc_o      = accept;
    assign rob_alloc_dest_o = issue_dest_i;

    // Control part of the issue register and the tag counter
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            ex_valid_q <= 1'b0;
            tag_q      <= '0;
        end else begin
            if (!mul_wait)
                ex_valid_q <= accept;
            // Tags track the reorder buffer tail and wrap with it
            if (accept)
                tag_q <= tag_q + 1'b1;
        end
    end

    // Payload part of the issue register
    always_ff @(posedge clk_i) begin
        if (accept) begin
            ex_unit_q   <= unit_of(issue_op_i);
            ex_op_o     <= issue_op_i;
            ex_tag_o    <= tag_q;
            ex_opnd_a_o <= opnd_a;
            ex_opnd_b_o <= opnd_b;
        end
    end

    // ALU work leaves at once, a multiply waits for a free multiplier
    assign alu_start_o = ex_valid_q && ex_unit_q == UNIT_ALU;
    assign mul_start_o = ex_valid_q && ex_unit_q == UNIT_MUL && !mul_busy_i;

    // After a multiply is launched the multiplier stays occupied for all its iterations
    a_mul_spacing : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        mul_start_o |=> !mul_start_o [*MUL_CYCLES])
        else $error("multiply started while the multiplier was busy");

endmodule : issue_stage

`default_nettype wire

// File: hdl/mul_unit.sv
// ================================================
// Iterative shift-add multiplier
// Several multiplier bits per cycle, low XLEN bits
// of the product, tag carried alongside
// ================================================
`timescale 1ns/1ps
`default_nettype none

module mul_unit
    import backend_cfg_pkg::*;
    import backend_op_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,
    input  logic       start_i,
    input  rob_tag_t   tag_i,
    input  data_word_t opnd_a_i,
    input  data_word_t opnd_b_i,
    output logic       busy_o,
    output logic       done_o,
    output rob_tag_t   tag_o,
    output data_word_t result_o
);

    mul_state_t           state_q;
    logic [MUL_CNT_W-1:0] iter_q;
    logic                 done_q;
    logic                 load;
    data_word_t           mcand_q, mplier_q, acc_q;
    data_word_t           digit, partial;

    // Unit is free again in the cycle it reports done
    assign busy_o   = state_q == MUL_BUSY && !done_q;
    assign done_o   = done_q;
    assign result_o = acc_q;
    assign load     = start_i && !busy_o;

    // One multiplier digit times the shifted multiplicand
    assign digit   = data_word_t'(mplier_q[MUL_BITS_PER_CYCLE-1:0]);
    assign partial = mcand_q * digit;

    // ================================================
    // Control FSM
    // ================================================

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= MUL_IDLE;
            iter_q  <= '0;
            done_q  <= 1'b0;
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (start_i)
                        state_q <= MUL_BUSY;
                    iter_q <= '0;
                end
                MUL_BUSY: begin
                    if (done_q) begin
                        // A waiting multiply may start right away
                        done_q <= 1'b0;
                        iter_q <= '0;
                        if (!start_i)
                            state_q <= MUL_IDLE;
                    end else begin
                        iter_q <= iter_q + 1'b1;
                        if (iter_q == MUL_CNT_W'(MUL_CYCLES - 1))
                            done_q <= 1'b1;
                    end
                end
                default: state_q <= MUL_IDLE;
            endcase
        end
    end

    // Datapath, reloaded on start and shifted on every busy cycle
    always_ff @(posedge clk_i) begin
        if (load) begin
            mcand_q  <= opnd_a_i;
            mplier_q <= opnd_b_i;
            acc_q    <= '0;
            tag_o    <= tag_i;
        end else if (busy_o) begin
            acc_q    <= acc_q + partial;
            mcand_q  <= mcand_q << MUL_BITS_PER_CYCLE;
            mplier_q <= mplier_q >> MUL_BITS_PER_CYCLE;
        end
    end

    // Done must drop before the FSM goes back to idle
    a_done_busy : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        state_q == MUL_IDLE |-> !done_o)
        else $error("multiplier done while idle");

endmodule : mul_unit

`default_nettype wire

// File: hdl/reorder_buffer.sv
// ================================================
// Reorder buffer
// Tag-indexed result store with forwarding lookup
// and in-order retirement to the register file
// ================================================
`timescale 1ns/1ps
`default_nettype none

module reorder_buffer
    import backend_cfg_pkg::*;
(
    input  logic       clk_i,
    input  logic       rst_n_i,

    // Allocation at issue
    input  logic       alloc_i,
    input  reg_addr_t  alloc_dest_i,
    output logic       full_o,

    // Completion from both units, possibly in the same cycle
    input  logic       alu_done_i,
    input  logic       mul_done_i,
    input  rob_tag_t   alu_tag_i,
    input  rob_tag_t   mul_tag_i,
    input  data_word_t alu_result_i,
    input  data_word_t mul_result_i,

    // Forwarding lookup
    input  reg_addr_t  fwd_src_a_i,
    input  reg_addr_t  fwd_src_b_i,
    output logic       fwd_hit_a_o,
    output logic       fwd_hit_b_o,
    output logic       fwd_pending_a_o,
    output logic       fwd_pending_b_o,
    output data_word_t fwd_data_a_o,
    output data_word_t fwd_data_b_o,

    // Writeback
    output logic       wb_valid_o,
    output reg_addr_t  wb_dest_o,
    output data_word_t wb_result_o
);

    reg_addr_t            dest_q   [ROB_DEPTH];
    data_word_t           result_q [ROB_DEPTH];
    logic [ROB_DEPTH-1:0] done_q;
    rob_tag_t             head_q, tail_q;
    logic [TAG_W:0]       count_q;
    logic                 retire;

    // Per-entry view including results that arrive in this cycle
    logic [ROB_DEPTH-1:0] live, ready, alu_wr, mul_wr;
    data_word_t           view [ROB_DEPTH];

    // Depth is a power of two, so the top count bit alone means full
    assign full_o = count_q[TAG_W];

    for (genvar i = 0; i < ROB_DEPTH; i++) begin : g_entry
        rob_tag_t age;

        // Distance from the head decides whether the slot is occupied
        assign age       = rob_tag_t'(i) - head_q;
        assign live[i]   = {1'b0, age} < count_q;
        assign alu_wr[i] = alu_done_i && alu_tag_i == rob_tag_t'(i);
        assign mul_wr[i] = mul_done_i && mul_tag_i == rob_tag_t'(i);
        assign ready[i]  = done_q[i] || alu_wr[i] || mul_wr[i];
        assign view[i]   = alu_wr[i] ? alu_result_i :
                           mul_wr[i] ? mul_result_i : result_q[i];
    end

    // ================================================
    // Forwarding search
    // ================================================

    // Walks from oldest to youngest so that the youngest writer of src wins
    function automatic void lookup(input reg_addr_t src, output logic hit,
                                   output logic pending, output data_word_t data);
        rob_tag_t idx;
        hit     = 1'b0;
        pending = 1'b0;
        data    = '0;
        for (int k = 0; k < ROB_DEPTH; k++) begin
            idx = head_q + rob_tag_t'(k);
            if (live[idx] && dest_q[idx] == src) begin
                hit     = 1'b1;
                pending = !ready[idx];
                data    = view[idx];
            end
        end
    endfunction

    always_comb begin
        lookup(fwd_src_a_i, fwd_hit_a_o, fwd_pending_a_o, fwd_data_a_o);
        lookup(fwd_src_b_i, fwd_hit_b_o, fwd_pending_b_o, fwd_data_b_o);
    end

    // ================================================
    // Retirement and pointers
    // ================================================

    // The head leaves one cycle after it completes, destination 0 leaves quietly
    assign retire      = count_q != '0 && done_q[head_q];
    assign wb_valid_o  = retire && dest_q[head_q] != '0;
    assign wb_dest_o   = dest_q[head_q];
    assign wb_result_o = result_q[head_q];

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            done_q  <= '0;
        end else begin
            if (alloc_i) begin
                done_q[tail_q] <= 1'b0;
                tail_q         <= tail_q + 1'b1;
            end
            if (alu_done_i)
                done_q[alu_tag_i] <= 1'b1;
            if (mul_done_i)
                done_q[mul_tag_i] <= 1'b1;
            if (retire)
                head_q <= head_q + 1'b1;
            count_q <= count_q + alloc_i - retire;
        end
    end

    // Entry payload
    always_ff @(posedge clk_i) begin
        if (alloc_i)
            dest_q[tail_q] <= alloc_dest_i;
        if (alu_done_i)
            result_q[alu_tag_i] <= alu_result_i;
        if (mul_done_i)
            result_q[mul_tag_i] <= mul_result_i;
    end

    // The issue stage stalls on full, so no entry is ever overwritten
    a_no_overflow : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        alloc_i |-> !full_o)
        else $error("allocation into a full reorder buffer");

    a_no_wb_r0 : assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o |-> wb_dest_o != '0)
        else $error("writeback to register 0");

endmodule : reorder_buffer

`default_nettype wire

// File: tb/tb_backend_ref.svh
// ================================================
// Testbench reference helpers
// Operation model, LFSR step and compare tasks
// ================================================
`ifndef TB_BACKEND_REF_SVH
`define TB_BACKEND_REF_SVH

// Expected result of one operation, written from the operation list
function automatic data_word_t ref_op(input alu_op_t op, input data_word_t a,
                                      input data_word_t b);
    data_word_t r;
    case (op)
        OP_ADD:  r = a + b;
        OP_SUB:  r = a - b;
        OP_AND:  r = a & b;
        OP_OR:   r = a | b;
        OP_XOR:  r = a ^ b;
        // Shift amount is the low 5 bits of b
        OP_SLL:  r = a << b[4:0];
        OP_SRL:  r = a >> b[4:0];
        OP_SLT:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        // Only the low word of the product is kept
        OP_MUL:  r = a * b;
        default: r = '0;
    endcase
    return r;
endfunction

// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1, one bit per step
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
endfunction

// Destination register of a writeback
task automatic check_dest(input string name, input reg_addr_t exp, input reg_addr_t act);
    if (act !== exp) begin
        $display("[FAIL] %s dest: expected r%0d, actual r%0d", name, exp, act);
        abort_run();
    end
endtask

// Result value of a writeback
task automatic check_data(input string name, input data_word_t exp, input data_word_t act);
    if (act !== exp) begin
        $display("[FAIL] %s result: expected 0x%08h, actual 0x%08h", name, exp, act);
        abort_run();
    end
endtask

`endif

// File: tb/tb_backend.sv
// ================================================
// Back end testbench
// Drives the issue port from a register file fed by
// writebacks and checks retirement against a model
// ================================================
`timescale 1ns/1ps
`default_nettype none

module tb_backend
    import backend_cfg_pkg::*;
    import backend_op_pkg::*;
();

    // ================================================
    // Run length and limits
    // ================================================

    localparam int RESET_CYCLES = 8;
    localparam int N_OPS        = 18;
    localparam int N_CHAIN      = 19;
    localparam int N_MUL_ORDER  = 8;
    localparam int N_MUL_FLOOD  = 12;
    localparam int N_REG_ZERO   = 6;
    localparam int N_RANDOM     = 200;
    localparam int N_TOTAL      = N_OPS + N_CHAIN + N_MUL_ORDER + N_MUL_FLOOD
                                + N_REG_ZERO + N_RANDOM;
    // Worst case per instruction is a full multiply plus a full reorder buffer
    localparam int TIMEOUT_CYCLES = N_TOTAL * (MUL_CYCLES + ROB_DEPTH + 4) + RESET_CYCLES;
    localparam int DRAIN_CYCLES   = 20;

    logic       clk_i;
    logic       rst_n_i;
    logic       issue_valid_i;
    logic       issue_imm_i;
    alu_op_t    issue_op_i;
    reg_addr_t  issue_dest_i;
    reg_addr_t  issue_src_a_i;
    reg_addr_t  issue_src_b_i;
    data_word_t issue_opnd_a_i;
    data_word_t issue_opnd_b_i;
    logic       stall_o;
    logic       wb_valid_o;
    reg_addr_t  wb_dest_o;
    data_word_t wb_result_o;

    // Register file seen by the issue port, written only by DUT writebacks
    data_word_t tb_rf [32] = '{default: '0};
    // Program-order model of the same registers
    data_word_t ref_rf [32] = '{default: '0};

    // Expected writebacks in issue order
    reg_addr_t  exp_dest_q [$];
    data_word_t exp_data_q [$];
    string      exp_name_q [$];

    string       test_name = "reset";
    logic [31:0] lfsr_q = 32'h4ec2;
    int          nz_accepted = 0;
    int          wb_count = 0;
    int          stall_cycles = 0;
    int          cycle_count = 0;

    backend_top DUT (
        .clk_i          ( clk_i          ),
        .rst_n_i        ( rst_n_i        ),
        .issue_valid_i  ( issue_valid_i  ),
        .issue_imm_i    ( issue_imm_i    ),
        .issue_op_i     ( issue_op_i     ),
        .issue_dest_i   ( issue_dest_i   ),
        .issue_src_a_i  ( issue_src_a_i  ),
        .issue_src_b_i  ( issue_src_b_i  ),
        .issue_opnd_a_i ( issue_opnd_a_i ),
        .issue_opnd_b_i ( issue_opnd_b_i ),
        .stall_o        ( stall_o        ),
        .wb_valid_o     ( wb_valid_o     ),
        .wb_dest_o      ( wb_dest_o      ),
        .wb_result_o    ( wb_result_o    )
    );

    always #5 clk_i = ~clk_i;

    // Reports the failure and ends the run
    task automatic abort_run();
        $display("TEST FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "tb_backend_ref.svh"

    // Collects n bits from the LFSR, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_step(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // Presents one instruction and waits until it is accepted
    task automatic issue_instr(input alu_op_t op, input reg_addr_t dest, input reg_addr_t sa,
                               input reg_addr_t sb, input logic imm, input data_word_t imm_val);
        data_word_t exp_val;
        @(negedge clk_i);
        issue_valid_i  = 1'b1;
        issue_op_i     = op;
        issue_dest_i   = dest;
        issue_src_a_i  = sa;
        issue_src_b_i  = sb;
        issue_imm_i    = imm;
        issue_opnd_a_i = tb_rf[sa];
        issue_opnd_b_i = imm ? imm_val : tb_rf[sb];
        #1;
        // The instruction is held under stall, its register reads follow the register file
        while (stall_o) begin
            stall_cycles++;
            @(negedge clk_i);
            issue_opnd_a_i = tb_rf[sa];
            issue_opnd_b_i = imm ? imm_val : tb_rf[sb];
            #1;
        end
        // Accepted at the coming rising edge, so the model advances in program order
        exp_val = ref_op(op, ref_rf[sa], imm ? imm_val : ref_rf[sb]);
        if (dest != '0) begin
            ref_rf[dest] = exp_val;
            exp_dest_q.push_back(dest);
            exp_data_q.push_back(exp_val);
            exp_name_q.push_back(test_name);
        end
    endtask

    // ================================================
    // Writeback comparison
    // ================================================

    // Sampled on the falling edge, where the retire outputs are settled
    always @(negedge clk_i) begin : compare_wb
        string      name;
        reg_addr_t  exp_d;
        data_word_t exp_v;
        if (rst_n_i && wb_valid_o) begin
            if (exp_dest_q.size() == 0) begin
                $display("Unexpected writeback to r%0d with nothing outstanding", wb_dest_o);
                abort_run();
            end else begin
                name  = exp_name_q.pop_front();
                exp_d = exp_dest_q.pop_front();
                exp_v = exp_data_q.pop_front();
                check_dest(name, exp_d, wb_dest_o);
                check_data(name, exp_v, wb_result_o);
                tb_rf[wb_dest_o] <= wb_result_o;
                wb_count++;
            end
        end
    end

    // Instructions with a register result, counted at the issue handshake itself
    always @(posedge clk_i) begin
        if (rst_n_i && issue_valid_i && !stall_o && issue_dest_i != '0)
            nz_accepted++;
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    // ================================================
    // Stimulus
    // ================================================

    initial begin : stimulus
        int stall_before;
        clk_i          = 1'b0;
        rst_n_i        = 1'b0;
        issue_valid_i  = 1'b0;
        issue_imm_i    = 1'b0;
        issue_op_i     = OP_ADD;
        issue_dest_i   = '0;
        issue_src_a_i  = '0;
        issue_src_b_i  = '0;
        issue_opnd_a_i = '0;
        issue_opnd_b_i = '0;
        repeat (RESET_CYCLES) @(negedge clk_i);
        rst_n_i = 1'b1;

        // Every ALU operation with register and immediate b
        test_name = "alu_ops";
        issue_instr(OP_ADD, 1, 0, 0, 1'b1, 32'h8000_1234);
        issue_instr(OP_ADD, 2, 0, 0, 1'b1, 32'hFFFF_FFF3);
        for (int k = 0; k < 8; k++) begin
            issue_instr(alu_op_t'(k), reg_addr_t'(3 + k), 1, 2, 1'b0, '0);
            issue_instr(alu_op_t'(k), reg_addr_t'(11 + k), 1, 0, 1'b1, 32'h0F0F_00A5);
        end

        // Back to back dependencies through fresh and parked results
        test_name = "dep_chain";
        issue_instr(OP_ADD, 5, 0, 0, 1'b1, 32'h0000_0003);
        for (int k = 0; k < 6; k++) begin
            issue_instr(OP_ADD, 5, 5, 0, 1'b1, data_word_t'(k * 7 + 1));
            issue_instr(OP_XOR, 6, 6, 5, 1'b0, '0);
            issue_instr(OP_SLL, 7, 6, 5, 1'b0, '0);
        end

        // Younger ALU results finish first but retire after the multiply
        test_name = "mul_order";
        issue_instr(OP_ADD, 8, 0, 0, 1'b1, 32'h1234_5678);
        issue_instr(OP_ADD, 9, 0, 0, 1'b1, 32'h9ABC_DEF1);
        issue_instr(OP_MUL, 10, 8, 9, 1'b0, '0);
        issue_instr(OP_ADD, 11, 8, 0, 1'b1, 32'h0000_0010);
        issue_instr(OP_XOR, 12, 9, 8, 1'b0, '0);
        issue_instr(OP_OR, 13, 8, 0, 1'b1, 32'h0000_00F0);
        issue_instr(OP_ADD, 14, 10, 9, 1'b0, '0);
        issue_instr(OP_MUL, 15, 10, 10, 1'b0, '0);

        // More multiplies than entries must push back on the issue port
        test_name = "mul_flood";
        stall_before = stall_cycles;
        for (int k = 0; k < N_MUL_FLOOD; k++) begin
            if (k % 2 == 1)
                issue_instr(OP_MUL, reg_addr_t'(16 + k % 8), 8, 0, 1'b1, data_word_t'(k + 3));
            else
                issue_instr(OP_MUL, reg_addr_t'(16 + k % 8), 8, 9, 1'b0, '0);
        end
        if (stall_cycles == stall_before) begin
            $display("mul_flood: stall_o never rose while multiplies were queued");
            abort_run();
        end

        // Register 0 as destination and as source
        test_name = "reg_zero";
        issue_instr(OP_ADD, 0, 8, 0, 1'b1, 32'h0000_0005);
        issue_instr(OP_MUL, 0, 8, 9, 1'b0, '0);
        issue_instr(OP_ADD, 20, 0, 0, 1'b1, 32'h0000_0007);
        issue_instr(OP_OR, 21, 0, 0, 1'b0, '0);
        issue_instr(OP_XOR, 0, 20, 20, 1'b0, '0);
        issue_instr(OP_ADD, 22, 0, 20, 1'b0, '0);

        // Random mix over a small register set to keep dependencies dense
        test_name = "random_mix";
        for (int n = 0; n < N_RANDOM; n++) begin : rand_instr
            alu_op_t    op;
            reg_addr_t  dest, sa, sb;
            logic       imm;
            data_word_t imm_val;
            op      = alu_op_t'(take_bits(4) % 9);
            dest    = reg_addr_t'(take_bits(3));
            sa      = reg_addr_t'(take_bits(3));
            sb      = reg_addr_t'(take_bits(3));
            imm     = take_bits(2) == 0;
            imm_val = take_bits(32);
            issue_instr(op, dest, sa, sb, imm, imm_val);
        end

        @(negedge clk_i);
        issue_valid_i = 1'b0;

        // Let outstanding work retire, then watch for stray writebacks
        while (exp_dest_q.size() != 0)
            @(negedge clk_i);
        repeat (DRAIN_CYCLES) @(negedge clk_i);

        if (wb_count == nz_accepted) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("[FAIL] end_of_run writebacks: expected %0d, actual %0d",
                     nz_accepted, wb_count);
            abort_run();
        end
    end

endmodule : tb_backend

`default_nettype wire
